// ==== common/operand_bit_if.sv ====
`default_nettype none

interface operand_bit_if #(
    parameter int data_width = serial_alu_pkg::DEFAULT_DATA_WIDTH
);
    import serial_alu_pkg::*;

    localparam int iw = index_width(data_width);

    logic          valid;
    logic          a_bit;
    logic          b_bit;
    alu_op_t       op;
    logic [iw-1:0] index;  // Bit position counted from the LSB
    logic          last;   // Set with the top bit

    modport source (
        output valid, a_bit, b_bit, op, index, last
    );

    modport sink (
        input valid, a_bit, b_bit, op, index, last
    );

endinterface

`default_nettype wire

// ==== common/result_bit_if.sv ====
`default_nettype none

interface result_bit_if #(
    parameter int data_width = serial_alu_pkg::DEFAULT_DATA_WIDTH
);
    import serial_alu_pkg::*;

    localparam int iw = index_width(data_width);

    logic          valid;
    logic          r_bit;
    logic [iw-1:0] index;
    logic          last;
    logic          carry;  // Final carry when last is set

    modport source (
        output valid, r_bit, index, last, carry
    );

    modport sink (
        input valid, r_bit, index, last, carry
    );

endinterface

`default_nettype wire

// ==== common/serial_alu_pkg.sv ====
`default_nettype none

package serial_alu_pkg;

    parameter int DEFAULT_DATA_WIDTH = 16;

    // ALU opcode encoding
    typedef enum logic [2:0] {
        op_add  = 3'b000,
        op_sub  = 3'b001,
        op_xor  = 3'b010,
        op_and  = 3'b011,
        op_not  = 3'b100,
        op_or   = 3'b101,
        op_nor  = 3'b110,
        op_nand = 3'b111
    } alu_op_t;

    // Bits needed to number the positions of a data word
    function automatic int index_width(input int data_width);
        return (data_width > 1) ? $clog2(data_width) : 1;
    endfunction

    // Operations that use the carry chain
    function automatic logic is_arith(input alu_op_t op);
        return (op == op_add) || (op == op_sub);
    endfunction

endpackage

`default_nettype wire

// ==== files.f ====
common/serial_alu_pkg.sv
common/operand_bit_if.sv
common/result_bit_if.sv
src/operand_serializer.sv
src/bit_alu_stage.sv
src/result_collector.sv
src/serial_alu_top.sv
tests/serial_alu_tb.sv

// ==== src/bit_alu_stage.sv ====
`default_nettype none

module bit_alu_stage #(
    parameter int data_width = serial_alu_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic          clk,
    input  logic          reset,
    operand_bit_if.sink   ops,
    result_bit_if.source  res
);
    import serial_alu_pkg::*;

    localparam int iw = index_width(data_width);

    logic          carry_q;  // Running carry between bits
    logic          valid_q;
    logic          r_bit_q;
    logic [iw-1:0] index_q;
    logic          last_q;

    logic          cin;
    logic          b_eff;
    logic          sum;
    logic          cout;
    logic          r_next;

    always_comb begin
        // Subtract seeds the first bit with the +1 of two's complement
        cin   = (ops.index == '0) ? (ops.op == op_sub) : carry_q;
        b_eff = ops.b_bit ^ (ops.op == op_sub);
        sum   = ops.a_bit ^ b_eff ^ cin;
        cout  = (ops.a_bit & b_eff) | (ops.a_bit & cin) | (b_eff & cin);

        case (ops.op)
            op_add,
            op_sub:  r_next = sum;
            op_xor:  r_next = ops.a_bit ^ ops.b_bit;
            op_and:  r_next = ops.a_bit & ops.b_bit;
            op_not:  r_next = ~ops.a_bit;
            op_or:   r_next = ops.a_bit | ops.b_bit;
            op_nor:  r_next = ~(ops.a_bit | ops.b_bit);
            op_nand: r_next = ~(ops.a_bit & ops.b_bit);
            default: r_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            carry_q <= 1'b0;
        end else begin
            valid_q <= ops.valid;
            if (ops.valid)
                carry_q <= is_arith(ops.op) ? cout : 1'b0;  // Logic ops keep it clear
        end
    end

    always_ff @(posedge clk) begin
        if (ops.valid) begin
            r_bit_q <= r_next;
            index_q <= ops.index;
            last_q  <= ops.last;
        end
    end

    assign res.valid = valid_q;
    assign res.r_bit = r_bit_q;
    assign res.index = index_q;
    assign res.last  = last_q;
    assign res.carry = carry_q;

endmodule

`default_nettype wire

// ==== src/operand_serializer.sv ====
`default_nettype none

module operand_serializer #(
    parameter int data_width = serial_alu_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  serial_alu_pkg::alu_op_t  op,
    input  logic [data_width-1:0]    a,
    input  logic [data_width-1:0]    b,
    output logic                     busy,
    operand_bit_if.source            ops,
    input  logic                     done_seen
);
    import serial_alu_pkg::*;

    localparam int iw = index_width(data_width);
    localparam logic [iw-1:0] last_index = iw'(data_width - 1);

    logic [data_width-1:0] a_sh;
    logic [data_width-1:0] b_sh;
    alu_op_t               op_q;
    logic [iw-1:0]         count;
    logic                  valid_q;
    logic                  busy_q;
    logic                  accept;

    // Busy drops in the done cycle so a new start can be taken there
    assign busy   = busy_q && !done_seen;
    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            count   <= '0;
        end else if (accept) begin
            busy_q  <= 1'b1;
            valid_q <= 1'b1;
            count   <= '0;
        end else begin
            if (done_seen)
                busy_q <= 1'b0;
            if (valid_q) begin
                if (count == last_index)
                    valid_q <= 1'b0;  // Whole word sent
                else
                    count <= count + 1'b1;
            end
        end
    end

    // Operand shift registers send the LSB first
    always_ff @(posedge clk) begin
        if (accept) begin
            a_sh <= a;
            b_sh <= b;
            op_q <= op;
        end else if (valid_q) begin
            a_sh <= a_sh >> 1;
            b_sh <= b_sh >> 1;
        end
    end

    assign ops.valid = valid_q;
    assign ops.a_bit = a_sh[0];
    assign ops.b_bit = b_sh[0];
    assign ops.op    = op_q;
    assign ops.index = count;
    assign ops.last  = (count == last_index);

endmodule

`default_nettype wire

// ==== src/result_collector.sv ====
`default_nettype none

module result_collector #(
    parameter int data_width = serial_alu_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    result_bit_if.sink            res,
    output logic                  done,
    output logic [data_width:0]   result
);

    // One-cycle pulse after the top bit lands
    always_ff @(posedge clk) begin
        if (reset)
            done <= 1'b0;
        else
            done <= res.valid && res.last;
    end

    // Bits overwrite the previous word one position at a time
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (res.valid) begin
            result[res.index] <= res.r_bit;
            if (res.last)
                result[data_width] <= res.carry;  // Carry out of the top bit
        end
    end

endmodule

`default_nettype wire

// ==== src/serial_alu_top.sv ====
`default_nettype none

module serial_alu_top #(
    parameter int data_width = serial_alu_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  serial_alu_pkg::alu_op_t  op,
    input  logic [data_width-1:0]    a,
    input  logic [data_width-1:0]    b,
    output logic                     busy,
    output logic                     done,
    output logic [data_width:0]      result
);

    operand_bit_if #(.data_width(data_width)) ops ();
    result_bit_if  #(.data_width(data_width)) res ();

    operand_serializer #(.data_width(data_width)) operand_serializer_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .op        (op),
        .a         (a),
        .b         (b),
        .busy      (busy),
        .ops       (ops.source),
        .done_seen (done)
    );

    bit_alu_stage #(.data_width(data_width)) bit_alu_stage_i (
        .clk   (clk),
        .reset (reset),
        .ops   (ops.sink),
        .res   (res.source)
    );

    result_collector #(.data_width(data_width)) result_collector_i (
        .clk    (clk),
        .reset  (reset),
        .res    (res.sink),
        .done   (done),
        .result (result)
    );

endmodule

`default_nettype wire

// ==== tests/serial_alu_tb.sv ====
`default_nettype none

module serial_alu_tb;
    import serial_alu_pkg::*;

    localparam int data_width = DEFAULT_DATA_WIDTH;
    localparam int wait_limit = 4 * data_width;  // Cycles before a wait gives up
    localparam int idle_limit = 400;

    logic                  clk;
    logic                  reset;
    logic                  start;
    alu_op_t               op;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic                  busy;
    logic                  done;
    logic [data_width:0]   result;

    // Operations in flight in issue order
    logic [data_width:0]   want_q[$];
    logic [2:0]            op_log[$];
    logic [data_width-1:0] a_log[$];
    logic [data_width-1:0] b_log[$];

    logic [31:0] rng_state = 32'h6dfe_51c2;
    int          errors    = 0;
    int          issued    = 0;
    int          checked   = 0;
    bit          hung      = 1'b0;  // Set once a wait runs out of cycles

    serial_alu_top #(.data_width(data_width)) serial_alu_top_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected word with the carry or no-borrow flag on top
    function automatic logic [data_width:0] expected_result(input alu_op_t f,
                                                            input logic [data_width-1:0] x,
                                                            input logic [data_width-1:0] y);
        logic [data_width:0] r;
        r = '0;
        case (f)
            op_add:  r = {1'b0, x} + {1'b0, y};
            op_sub: begin
                r[data_width-1:0] = x - y;
                r[data_width]     = (x >= y);  // No borrow
            end
            op_xor:  r[data_width-1:0] = x ^ y;
            op_and:  r[data_width-1:0] = x & y;
            op_not:  r[data_width-1:0] = ~x;
            op_or:   r[data_width-1:0] = x | y;
            op_nor:  r[data_width-1:0] = ~(x | y);
            op_nand: r[data_width-1:0] = ~(x & y);
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic random_word(output logic [data_width-1:0] v);
        rng_state = xorshift(rng_state);
        v = rng_state[data_width-1:0];
    endtask

    task automatic note_timeout(input string why);
        errors++;
        hung = 1'b1;
        $display("%s at time %0t", why, $time);
    endtask

    // Issues one operation and follows busy and done until it completes
    task automatic run_op(input alu_op_t f, input logic [data_width-1:0] x,
                          input logic [data_width-1:0] y, input bit poke);
        int k;
        bit seen;
        k    = 0;
        seen = 1'b0;
        while (!hung && busy !== 1'b0 && k < wait_limit) begin
            @(negedge clk);
            k++;
        end
        if (!hung && busy !== 1'b0)
            note_timeout("busy never dropped before a new start");
        if (!hung) begin
            @(posedge clk);
            start <= 1'b1;
            op    <= f;
            a     <= x;
            b     <= y;
            want_q.push_back(expected_result(f, x, y));
            op_log.push_back(f);
            a_log.push_back(x);
            b_log.push_back(y);
            issued++;
            k = 0;
            while (!seen && k < wait_limit) begin
                @(posedge clk);
                k++;
                if (poke && k == 4) begin
                    start <= 1'b1;  // Arrives while busy
                    op    <= alu_op_t'(f + 3'd3);
                    a     <= ~x;
                    b     <= x ^ y;
                end else begin
                    start <= 1'b0;
                end
                @(negedge clk);
                if (done === 1'b1) begin
                    seen = 1'b1;
                    if (k != data_width + 2) begin
                        errors++;
                        $display("ERR %0t: done %0d cycles after start, expected %0d",
                                 $time, k, data_width + 2);
                    end
                    if (busy !== 1'b0) begin
                        errors++;
                        $display("ERR %0t: busy still high with done", $time);
                    end
                end else if (busy !== 1'b1) begin
                    errors++;
                    $display("ERR %0t: busy low in cycle %0d of an operation", $time, k);
                end
            end
            if (!seen)
                note_timeout("done never arrived");
        end
    endtask

    initial begin : compare_results
        logic [data_width:0]   want;
        logic [data_width-1:0] x;
        logic [data_width-1:0] y;
        logic [2:0]            f;
        int                    idle;
        while (!hung) begin
            idle = 0;
            while (want_q.size() == 0 && idle < idle_limit) begin
                @(negedge clk);
                idle++;
            end
            if (want_q.size() == 0) begin
                note_timeout("no operation reached the checker");
            end else begin
                idle = 0;
                do begin
                    @(negedge clk);
                    idle++;
                end while (done !== 1'b1 && idle < wait_limit);
                if (done !== 1'b1) begin
                    note_timeout("done never arrived");
                end else begin
                    want = want_q.pop_front();
                    f    = op_log.pop_front();
                    x    = a_log.pop_front();
                    y    = b_log.pop_front();
                    checked++;
                    if (result !== want) begin
                        errors++;
                        $display("ERR %0t: op %0d a %h b %h result %h expected %h",
                                 $time, f, x, y, result, want);
                    end
                    if (f > 3'd1 && result[data_width] !== 1'b0) begin
                        errors++;
                        $display("ERR %0t: op %0d left bit %0d set", $time, f, data_width);
                    end
                end
            end
        end
    end

    initial begin : stimulus
        logic [data_width-1:0] x;
        logic [data_width-1:0] y;
        int                    n;
        int                    k;
        clk   = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        op    = op_add;
        a     = '0;
        b     = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b0 || done !== 1'b0 || result !== '0) begin
            errors++;
            $display("ERR %0t: after reset busy %b done %b result %h",
                     $time, busy, done, result);
        end

        // Carry out, wrap and borrow, then zero operands to catch a stale carry
        run_op(op_add, '0, '0, 1'b0);
        run_op(op_add, {data_width{1'b1}}, 1, 1'b0);
        run_op(op_add, '0, '0, 1'b0);
        run_op(op_add, 1, 2, 1'b0);
        run_op(op_sub, '0, '0, 1'b0);
        run_op(op_sub, {data_width{1'b1}}, 1, 1'b0);
        run_op(op_sub, 1, 2, 1'b0);
        run_op(op_and, {data_width{1'b1}}, {data_width{1'b1}}, 1'b0);

        for (n = 0; n < 12; n++) begin
            random_word(x);
            random_word(y);
            run_op((n % 2) ? op_sub : op_add, x, y, n == 5);
        end

        for (n = 2; n < 8; n++) begin
            for (k = 0; k < 3; k++) begin
                random_word(x);
                random_word(y);
                run_op(alu_op_t'(n), x, y, k == 1);
            end
        end

        k = 0;
        while (checked < issued && k < wait_limit) begin
            @(negedge clk);
            k++;
        end
        if (checked < issued) begin
            errors++;
            $display("checker compared only %0d of %0d operations", checked, issued);
        end

        $display("checks: %0d, errors: %0d", checked, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
